// File: project.f
hdl/dcache_pkg.sv
hdl/line_ram.sv
hdl/cache_way.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/dcache_checker.sv
bench/tb_dcache.sv

// File: bench/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          TIMEOUT  = 200;
    localparam logic [31:0] SEED     = 32'h26cb_7bf1;
    localparam tag_t        TAG_BASE = 20'h8_0010;   // low 3 tag bits pick the test tag

    typedef struct packed {
        logic  hit;
        logic  wb;
        addr_t wb_addr;
        line_t wb_line;
        word_t rdata;
    } ref_result_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     cpu_valid_i;
    cpu_req_t cpu_req_i;
    logic     cpu_addr_ok_o;
    logic     cpu_data_ok_o;
    word_t    cpu_rdata_o;
    logic     mem_rd_req_o;
    addr_t    mem_rd_addr_o;
    logic     mem_rd_rdy_i;
    logic     mem_ret_valid_i;
    line_t    mem_ret_data_i;
    logic     mem_wr_req_o;
    addr_t    mem_wr_addr_o;
    line_t    mem_wr_data_o;
    logic     mem_wr_rdy_i;

    line_t mem [0:1023];        // memory model backing store
    line_t ref_mem [0:1023];
    tag_t  ref_tag [0:1][0:SETS-1];
    line_t ref_line [0:1][0:SETS-1];
    logic  ref_valid [0:1][0:SETS-1];
    logic  ref_dirty [0:1][0:SETS-1];
    logic  ref_lru [0:SETS-1];

    logic        ret_pending = 1'b0;
    logic [1:0]  ret_wait;
    int          ret_slot;
    logic [31:0] stall_rng = ~SEED;
    logic [31:0] stim_rng  = SEED;
    logic        hung      = 1'b0;

    dcache_top u_dut (.*);

    dcache_checker u_check (
        .clk           (clk),
        .cpu_valid_i   (cpu_valid_i),
        .cpu_addr_ok_i (cpu_addr_ok_o),
        .cpu_data_ok_i (cpu_data_ok_o),
        .cpu_rdata_i   (cpu_rdata_o),
        .mem_rd_req_i  (mem_rd_req_o),
        .mem_rd_rdy_i  (mem_rd_rdy_i),
        .mem_rd_addr_i (mem_rd_addr_o),
        .mem_wr_req_i  (mem_wr_req_o),
        .mem_wr_rdy_i  (mem_wr_rdy_i),
        .mem_wr_addr_i (mem_wr_addr_o),
        .mem_wr_data_i (mem_wr_data_o)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // low tag bits and set index give the memory slot
    function automatic int slot(addr_t a);
        return {a[OFFSET_W+INDEX_W +: 3], a[OFFSET_W +: INDEX_W]};
    endfunction

    function automatic word_t fill_word(addr_t a);
        return (a ^ 32'h5a5a_1234) * 32'h9e37_79b9;
    endfunction

    function automatic addr_t mk_addr(int t, int idx, int wd);
        return {TAG_BASE | tag_t'(t), index_t'(idx), word_sel_t'(wd), 2'b00};
    endfunction

    // two ways per set, LRU bit names the next victim
    function automatic ref_result_t ref_access(cpu_req_t r);
        addr_fields_t f;
        ref_result_t  res;
        int           w;
        word_t        mask;
        f   = addr_fields_t'(r.addr);
        res = '0;
        w   = ref_lru[f.index];
        for (int i = 0; i < 2; i++) begin
            if (ref_valid[i][f.index] && ref_tag[i][f.index] == f.tag) begin
                res.hit = 1'b1;
                w = i;
            end
        end
        if (!res.hit) begin
            if (ref_valid[w][f.index] && ref_dirty[w][f.index]) begin
                res.wb      = 1'b1;
                res.wb_addr = {ref_tag[w][f.index], f.index, {OFFSET_W{1'b0}}};
                res.wb_line = ref_line[w][f.index];
                ref_mem[slot(res.wb_addr)] = res.wb_line;
            end
            ref_line[w][f.index]  = ref_mem[slot(r.addr)];
            ref_tag[w][f.index]   = f.tag;
            ref_valid[w][f.index] = 1'b1;
            ref_dirty[w][f.index] = 1'b0;
        end
        res.rdata = ref_line[w][f.index][f.word];
        for (int b = 0; b < 4; b++) mask[8*b +: 8] = {8{r.wstrb[b]}};
        if (r.op) begin
            ref_line[w][f.index][f.word] = (res.rdata & ~mask) | (r.wdata & mask);
            ref_dirty[w][f.index] = 1'b1;
        end
        ref_lru[f.index] = (w == 0);
        return res;
    endfunction

    task automatic init_models();
        for (int s = 0; s < 1024; s++) begin
            for (int k = 0; k < LINE_WORDS; k++)
                mem[s][k] = fill_word({TAG_BASE[TAG_W-1:3], s[9:0], k[2:0], 2'b00});
            ref_mem[s] = mem[s];
        end
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
            ref_lru[s] = 1'b0;
        end
    endtask

    // memory side with random ready stalls
    always @(posedge clk) begin : mem_model
        if (mem_wr_req_o && mem_wr_rdy_i) mem[slot(mem_wr_addr_o)] = mem_wr_data_o;
        if (mem_rd_req_o && mem_rd_rdy_i) begin
            ret_slot    = slot(mem_rd_addr_o);
            ret_wait    = stall_rng[5:4];
            ret_pending = 1'b1;
        end
        #2;
        stall_rng       = xorshift32(stall_rng);
        mem_wr_rdy_i    = (stall_rng[1:0] != 2'b00);
        mem_rd_rdy_i    = (stall_rng[3:2] != 2'b00);
        mem_ret_valid_i = 1'b0;
        if (ret_pending && ret_wait == 0) begin
            mem_ret_valid_i = 1'b1;
            mem_ret_data_i  = mem[ret_slot];
            ret_pending     = 1'b0;
        end else if (ret_pending) begin
            ret_wait--;
        end
    end

    task automatic do_access(input logic op, input addr_t addr, input logic [3:0] strb,
                             input word_t wdata);
        cpu_req_t    r;
        ref_result_t e;
        int          t;
        if (hung) return;
        r.op    = op;
        r.addr  = addr;
        r.wstrb = strb;
        r.wdata = wdata;
        e = ref_access(r);
        if (e.wb) u_check.expect_wb(e.wb_addr, e.wb_line);
        if (!e.hit) u_check.expect_rd({addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        u_check.expect_resp(!op, e.hit, e.rdata);
        cpu_req_i   = r;
        cpu_valid_i = 1'b1;
        t = 0;
        @(posedge clk);
        while (!cpu_addr_ok_o && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        #2;
        cpu_valid_i = 1'b0;
        if (t == TIMEOUT) begin
            u_check.note_failure($sformatf("cache gave no addr_ok within %0d cycles", TIMEOUT));
            hung = 1'b1;
            return;
        end
        t = 0;
        @(posedge clk);
        while (!cpu_data_ok_o && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        #2;
        if (t == TIMEOUT) begin
            u_check.note_failure($sformatf("cache gave no data_ok within %0d cycles", TIMEOUT));
            hung = 1'b1;
        end
    endtask

    initial begin
        cpu_valid_i     = 1'b0;
        cpu_req_i       = '0;
        mem_rd_rdy_i    = 1'b0;
        mem_wr_rdy_i    = 1'b0;
        mem_ret_valid_i = 1'b0;
        mem_ret_data_i  = '0;
        reset           = 1'b1;
        init_models();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        do_access(1'b0, mk_addr(0, 5, 3), 4'h0, '0);
        u_check.end_test("cold read");
        do_access(1'b0, mk_addr(0, 5, 3), 4'h0, '0);
        do_access(1'b0, mk_addr(0, 5, 6), 4'h0, '0);
        u_check.end_test("read hit");
        do_access(1'b1, mk_addr(0, 5, 3), 4'b0101, 32'hdead_beef);
        do_access(1'b0, mk_addr(0, 5, 3), 4'h0, '0);
        u_check.end_test("store hit");
        for (int t = 1; t <= 3; t++)
            do_access(1'b1, mk_addr(t, 20, t), 4'hf, 32'h0101_0101 * t);
        do_access(1'b0, mk_addr(1, 20, 1), 4'h0, '0);   // evicted line comes back
        u_check.end_test("dirty eviction");
        for (int i = 0; i < 400; i++) begin
            stim_rng = xorshift32(stim_rng);
            do_access(stim_rng[0], mk_addr(stim_rng[3:1] % 5, {stim_rng[5:4], 5'd3},
                      stim_rng[8:6]), stim_rng[12:9], xorshift32(stim_rng));
        end
        u_check.end_test("random mix");

        u_check.print_totals();
        if (u_check.errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: bench/dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker
    import dcache_pkg::*;
(
    input logic  clk,
    input logic  cpu_valid_i,
    input logic  cpu_addr_ok_i,
    input logic  cpu_data_ok_i,
    input word_t cpu_rdata_i,
    input logic  mem_rd_req_i,
    input logic  mem_rd_rdy_i,
    input addr_t mem_rd_addr_i,
    input logic  mem_wr_req_i,
    input logic  mem_wr_rdy_i,
    input addr_t mem_wr_addr_i,
    input line_t mem_wr_data_i
);

    typedef struct packed {
        logic  load;
        logic  hit;
        word_t data;
    } resp_exp_t;

    resp_exp_t resp_q[$];
    addr_t     rd_q[$];
    addr_t     wb_addr_q[$];
    line_t     wb_line_q[$];

    int errors       = 0;
    int test_errors  = 0;
    int tests        = 0;
    int loads        = 0;
    int rd_count     = 0;
    int wr_count     = 0;
    int cycle        = 0;
    int accept_cycle = 0;

    task automatic expect_resp(input logic load, input logic hit, input word_t data);
        resp_q.push_back({load, hit, data});
    endtask

    task automatic expect_rd(input addr_t addr);
        rd_q.push_back(addr);
    endtask

    task automatic expect_wb(input addr_t addr, input line_t line);
        wb_addr_q.push_back(addr);
        wb_line_q.push_back(line);
    endtask

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("FAILURE at %0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    always @(posedge clk) begin : monitor
        resp_exp_t e;
        cycle++;
        if (cpu_valid_i && cpu_addr_ok_i) accept_cycle = cycle;
        if (cpu_data_ok_i) begin
            if (resp_q.size() == 0) begin
                note_failure("data_ok without an outstanding request");
            end else begin
                e = resp_q.pop_front();
                if (e.hit != ((cycle - accept_cycle) == 1))  // hits answer in one cycle
                    mismatch($sformatf("hit predicted %0d, data_ok %0d cycles after accept",
                                       e.hit, cycle - accept_cycle));
                if (e.load) begin
                    loads++;
                    if (cpu_rdata_i !== e.data)
                        mismatch($sformatf("load returned %h, expected %h", cpu_rdata_i, e.data));
                end
            end
        end
        if (mem_wr_req_i && mem_wr_rdy_i) begin
            wr_count++;
            if (wb_addr_q.size() == 0) begin
                note_failure("write-back that the model did not predict");
            end else begin
                if (mem_wr_addr_i !== wb_addr_q[0])
                    mismatch($sformatf("write-back address %h, expected %h",
                                       mem_wr_addr_i, wb_addr_q[0]));
                if (mem_wr_data_i !== wb_line_q[0])
                    mismatch($sformatf("write-back line at %h differs from model", mem_wr_addr_i));
                void'(wb_addr_q.pop_front());
                void'(wb_line_q.pop_front());
            end
        end
        if (mem_rd_req_i && mem_rd_rdy_i) begin
            rd_count++;
            if (wb_addr_q.size() != 0) note_failure("refill request came before the write-back");
            if (rd_q.size() == 0) begin
                note_failure("read request that the model did not predict");
            end else if (mem_rd_addr_i !== rd_q[0]) begin
                mismatch($sformatf("read request address %h, expected %h", mem_rd_addr_i, rd_q[0]));
                void'(rd_q.pop_front());
            end else begin
                void'(rd_q.pop_front());
            end
        end
    end

    task automatic end_test(input string name);
        if (resp_q.size() != 0 || rd_q.size() != 0 || wb_addr_q.size() != 0)
            note_failure({name, ": a predicted response or memory request did not occur"});
        resp_q.delete();
        rd_q.delete();
        wb_addr_q.delete();
        wb_line_q.delete();
        tests++;
        $display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "PASS" : "FAIL",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic print_totals();
        $display("totals: %0d tests, %0d loads checked, %0d line reads, %0d write-backs, %0d errors",
                 tests, loads, rd_count, wr_count, errors);
    endtask

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    input  logic     cpu_valid_i,
    input  cpu_req_t cpu_req_i,
    output logic     cpu_addr_ok_o,
    output logic     cpu_data_ok_o,
    output word_t    cpu_rdata_o,

    output logic     mem_rd_req_o,
    output addr_t    mem_rd_addr_o,
    input  logic     mem_rd_rdy_i,
    input  logic     mem_ret_valid_i,
    input  line_t    mem_ret_data_i,
    output logic     mem_wr_req_o,
    output addr_t    mem_wr_addr_o,
    output line_t    mem_wr_data_o,
    input  logic     mem_wr_rdy_i
);

    way_lookup_t way0_lookup;
    way_lookup_t way1_lookup;
    way_write_t  way0_wr;
    way_write_t  way1_wr;
    index_t      rd_index;
    tag_t        lookup_tag;

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .reset           (reset),
        .cpu_valid_i     (cpu_valid_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_addr_ok_o   (cpu_addr_ok_o),
        .cpu_data_ok_o   (cpu_data_ok_o),
        .cpu_rdata_o     (cpu_rdata_o),
        .way0_i          (way0_lookup),
        .way1_i          (way1_lookup),
        .way0_wr_o       (way0_wr),
        .way1_wr_o       (way1_wr),
        .rd_index_o      (rd_index),
        .lookup_tag_o    (lookup_tag),
        .mem_rd_req_o    (mem_rd_req_o),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_rd_rdy_i    (mem_rd_rdy_i),
        .mem_ret_valid_i (mem_ret_valid_i),
        .mem_ret_data_i  (mem_ret_data_i),
        .mem_wr_req_o    (mem_wr_req_o),
        .mem_wr_addr_o   (mem_wr_addr_o),
        .mem_wr_data_o   (mem_wr_data_o),
        .mem_wr_rdy_i    (mem_wr_rdy_i)
    );

    cache_way u_way0 (
        .clk          (clk),
        .reset        (reset),
        .rd_index_i   (rd_index),
        .lookup_tag_i (lookup_tag),
        .wr_i         (way0_wr),
        .lookup_o     (way0_lookup)
    );

    cache_way u_way1 (
        .clk          (clk),
        .reset        (reset),
        .rd_index_i   (rd_index),
        .lookup_tag_i (lookup_tag),
        .wr_i         (way1_wr),
        .lookup_o     (way1_lookup)
    );

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        cpu_valid_i,
    input  cpu_req_t    cpu_req_i,
    output logic        cpu_addr_ok_o,
    output logic        cpu_data_ok_o,
    output word_t       cpu_rdata_o,

    input  way_lookup_t way0_i,
    input  way_lookup_t way1_i,
    output way_write_t  way0_wr_o,
    output way_write_t  way1_wr_o,
    output index_t      rd_index_o,
    output tag_t        lookup_tag_o,

    output logic        mem_rd_req_o,
    output addr_t       mem_rd_addr_o,
    input  logic        mem_rd_rdy_i,
    input  logic        mem_ret_valid_i,
    input  line_t       mem_ret_data_i,
    output logic        mem_wr_req_o,
    output addr_t       mem_wr_addr_o,
    output line_t       mem_wr_data_o,
    input  logic        mem_wr_rdy_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WBACK,
        S_RDREQ,
        S_WAIT,
        S_RESP
    } state_t;

    state_t          state;
    state_t          state_n;
    cpu_req_t        req_q;
    line_t           ret_line_q;
    logic [SETS-1:0] lru;       // way to replace next

    addr_fields_t       req_f;
    addr_fields_t       cpu_f;
    logic               accept;
    logic               hit0;
    logic               hit1;
    logic               hit;
    logic               victim;
    way_lookup_t        vict;
    line_t              base_line;
    line_t              wr_line;
    logic [WSTRB_W-1:0] strb_eff;
    logic               store_hit;
    logic               refill;
    way_write_t         wr_c;

    // replace the strobed bytes of one word
    function automatic line_t merge_word(line_t l, word_sel_t sel,
                                         logic [WSTRB_W-1:0] strb, word_t wd);
        line_t r;
        r = l;
        for (int b = 0; b < WSTRB_W; b++) begin
            if (strb[b]) begin
                r[sel][8*b +: 8] = wd[8*b +: 8];
            end
        end
        return r;
    endfunction

    assign req_f  = addr_fields_t'(req_q.addr);
    assign cpu_f  = addr_fields_t'(cpu_req_i.addr);
    assign accept = cpu_valid_i && (state == S_IDLE);

    assign hit0   = way0_i.hit;
    assign hit1   = way1_i.hit;
    assign hit    = hit0 || hit1;
    assign victim = lru[req_f.index];
    assign vict   = victim ? way1_i : way0_i;

    always_comb begin
        state_n = state;
        case (state)
            S_IDLE: begin
                if (accept) begin
                    state_n = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_n = S_IDLE;
                end else if (vict.dirty) begin
                    state_n = S_WBACK;
                end else begin
                    state_n = S_RDREQ;
                end
            end
            S_WBACK: begin
                if (mem_wr_rdy_i) begin
                    state_n = S_RDREQ;
                end
            end
            S_RDREQ: begin
                if (mem_rd_rdy_i) begin
                    state_n = S_WAIT;
                end
            end
            S_WAIT: begin
                if (mem_ret_valid_i) begin
                    state_n = S_RESP;
                end
            end
            S_RESP:  state_n = S_IDLE;
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            lru   <= '0;
        end else begin
            state <= state_n;
            if (state == S_LOOKUP && hit) begin
                lru[req_f.index] <= hit0;   // point at the other way
            end else if (refill) begin
                lru[req_f.index] <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req_i;
        end
        if (state == S_WAIT && mem_ret_valid_i) begin
            ret_line_q <= mem_ret_data_i;
        end
    end

    // hit line on lookup, refill line on response
    assign base_line = (state == S_RESP) ? ret_line_q : (hit1 ? way1_i.line : way0_i.line);
    assign strb_eff  = req_q.op ? req_q.wstrb : '0;
    assign wr_line   = merge_word(base_line, req_f.word, strb_eff, req_q.wdata);
    assign store_hit = (state == S_LOOKUP) && hit && req_q.op;
    assign refill    = (state == S_RESP);

    always_comb begin
        wr_c.we    = 1'b0;
        wr_c.index = req_f.index;
        wr_c.tag   = req_f.tag;
        wr_c.line  = wr_line;
        wr_c.dirty = req_q.op;  // loads refill clean

        way0_wr_o    = wr_c;
        way0_wr_o.we = (store_hit && hit0) || (refill && !victim);
        way1_wr_o    = wr_c;
        way1_wr_o.we = (store_hit && hit1) || (refill && victim);
    end

    assign rd_index_o   = (state == S_IDLE) ? cpu_f.index : req_f.index;
    assign lookup_tag_o = req_f.tag;

    assign cpu_addr_ok_o = accept;
    assign cpu_data_ok_o = ((state == S_LOOKUP) && hit) || refill;
    assign cpu_rdata_o   = base_line[req_f.word];

    assign mem_wr_req_o  = (state == S_WBACK);
    assign mem_wr_addr_o = line_addr(vict.tag, req_f.index);
    assign mem_wr_data_o = vict.line;

    assign mem_rd_req_o  = (state == S_RDREQ);
    assign mem_rd_addr_o = line_addr(req_f.tag, req_f.index);

endmodule

// File: hdl/cache_way.sv
`timescale 1ns/1ns

module cache_way
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  index_t      rd_index_i,
    input  tag_t        lookup_tag_i,
    input  way_write_t  wr_i,
    output way_lookup_t lookup_o
);

    index_t ram_addr;
    tag_t   tag_q;
    line_t  line_q;

    logic [SETS-1:0] valid;
    logic [SETS-1:0] dirty;
    logic            valid_q;
    logic            dirty_q;

    // a write owns the port for its cycle
    assign ram_addr = wr_i.we ? wr_i.index : rd_index_i;

    line_ram #(
        .T     (tag_t),
        .DEPTH (SETS)
    ) u_tag_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .we_i    (wr_i.we),
        .wdata_i (wr_i.tag),
        .rdata_o (tag_q)
    );

    line_ram #(
        .T     (line_t),
        .DEPTH (SETS)
    ) u_data_ram (
        .clk     (clk),
        .addr_i  (ram_addr),
        .we_i    (wr_i.we),
        .wdata_i (wr_i.line),
        .rdata_o (line_q)
    );

    // state bits read the same set as the RAMs, one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            valid   <= '0;
            dirty   <= '0;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            if (wr_i.we) begin
                valid[wr_i.index] <= 1'b1;
                dirty[wr_i.index] <= wr_i.dirty;
            end
            valid_q <= valid[ram_addr];
            dirty_q <= dirty[ram_addr];
        end
    end

    always_comb begin
        lookup_o.hit   = valid_q && (tag_q == lookup_tag_i);
        lookup_o.dirty = dirty_q;
        lookup_o.tag   = tag_q;
        lookup_o.line  = line_q;
    end

endmodule

// File: hdl/line_ram.sv
`timescale 1ns/1ns

module line_ram
    import dcache_pkg::*;
#(
    parameter type T     = logic,
    parameter int  DEPTH = SETS
) (
    input  logic   clk,
    input  index_t addr_i,
    input  logic   we_i,
    input  T       wdata_i,
    output T       rdata_o
);

    T mem [0:DEPTH-1];

    // read returns the old contents on a write cycle
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    parameter int ADDR_W     = 32;
    parameter int WORD_W     = 32;
    parameter int OFFSET_W   = 5;   // byte offset in a line
    parameter int INDEX_W    = 7;
    parameter int TAG_W      = 20;
    parameter int LINE_WORDS = 8;
    parameter int SETS       = 128;
    parameter int WSEL_W     = $clog2(LINE_WORDS);
    parameter int WSTRB_W    = WORD_W / 8;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WSEL_W-1:0]  word_sel_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    // byte address split into its cache fields
    typedef struct packed {
        tag_t                         tag;
        index_t                       index;
        word_sel_t                    word;
        logic [OFFSET_W-WSEL_W-1:0]   byte_off;
    } addr_fields_t;

    typedef struct packed {
        logic               op;     // 1 = write
        addr_t              addr;
        logic [WSTRB_W-1:0] wstrb;
        word_t              wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  hit;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_lookup_t;

    typedef struct packed {
        logic   we;
        index_t index;
        tag_t   tag;
        line_t  line;
        logic   dirty;  // new dirty value
    } way_write_t;

    // line-aligned address from tag and set
    function automatic addr_t line_addr(tag_t tag, index_t index);
        return {tag, index, {OFFSET_W{1'b0}}};
    endfunction

endpackage
